// File: compile.f
src/axi_pkg.sv
src/xbar_pkg.sv
src/axi4_arbiter_r.sv
src/axi4_ar_mux.sv
src/axi4_r_demux.sv
src/axi4_xbar_r.sv
verification/tb_clock.sv
verification/tb_axi_slave.sv
verification/axi4_xbar_r_tb.sv

// File: src/axi4_ar_mux.sv
//////////////////////////////
// AR channel select for two masters.
// Purely combinational, steered by the grant.
//////////////////////////////
`timescale 1ns/10ps

module axi4_ar_mux
   import axi_pkg::*;
   import xbar_pkg::*;
(
   input  grant_t grant,                        // one-hot owner from the arbiter.
   // master 0
   input  logic   s0_arvalid,
   input  ar_t    s0_ar,
   output logic   s0_arready,
   // master 1
   input  logic   s1_arvalid,
   input  ar_t    s1_ar,
   output logic   s1_arready,
   // slave
   output logic   m_arvalid,
   output ar_t    m_ar,
   input  logic   m_arready
);

   logic s0_sel;                                // master 0 owns the path.
   logic s1_sel;                                // master 1 owns the path.

   assign s0_sel = grant[0];
   assign s1_sel = grant[1];

   //////////////////////////////
   // toward the slave
   //////////////////////////////

   // the non-owner's request is masked here and waits for its turn.
   assign m_arvalid = (s0_sel & s0_arvalid) | (s1_sel & s1_arvalid);

   always_comb
   begin
      if (s1_sel)
         m_ar = s1_ar;                          // master 1 payload.
      else
         m_ar = s0_ar;                          // master 0 payload.
   end

   //////////////////////////////
   // back to the masters
   //////////////////////////////

   assign s0_arready = s0_sel & m_arready;      // only the owner sees the slave ready.
   assign s1_arready = s1_sel & m_arready;      // the other master sees it low.

endmodule

// File: src/axi4_arbiter_r.sv
//////////////////////////////
// Read path owner for two masters, round-robin on rlast.
// Each master may have only one burst outstanding.
// m_rready must already be the owner's rready.
//////////////////////////////
`timescale 1ns/10ps

module axi4_arbiter_r
   import xbar_pkg::*;
#(
   parameter mst_idx_t init_owner = 1'b0        // owner after reset.
)
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   s0_arvalid,                   // master 0 requests the path.
   input  logic   s1_arvalid,                   // master 1 requests the path.
   input  logic   m_rvalid,                     // slave r beat valid.
   input  logic   m_rready,                     // owner rready as seen by the slave.
   input  logic   m_rlast,                      // slave r beat is the last one.
   output grant_t grant                         // one-hot owner.
);

   grant_t grant_q;                             // current owner.
   grant_t grant_d;                             // owner for the next cycle.
   logic   s0_pending_q;                        // master 0 has a burst in flight.
   logic   s1_pending_q;                        // master 1 has a burst in flight.
   logic   s0_pending_set;
   logic   s1_pending_set;
   logic   s0_pending_clr;
   logic   s1_pending_clr;
   logic   last_done;                           // last r beat transfers this cycle.

   //////////////////////////////
   // burst completion
   //////////////////////////////

   // only the owner's rready reaches the slave, so no per-master term is needed.
   assign last_done      = m_rvalid & m_rready & m_rlast;
   assign s0_pending_clr = grant_q[0] & last_done; // master 0 got its last beat.
   assign s1_pending_clr = grant_q[1] & last_done; // master 1 got its last beat.

   //////////////////////////////
   // next owner
   //////////////////////////////

   always_comb
   begin
      grant_d        = grant_q;                 // hold by default.
      s0_pending_set = 1'b0;
      s1_pending_set = 1'b0;
      case (grant_q)
         grant_m0:
         begin
            if (s0_arvalid)
               s0_pending_set = 1'b1;           // owner asks again, keep it.
            else if (s0_pending_q & ~last_done)
               grant_d = grant_m0;              // burst still running, path stays locked.
            else if (last_done)
               grant_d = grant_m1;              // round-robin after the last beat.
            else if (s1_arvalid)
            begin
               grant_d        = grant_m1;       // idle owner, hand over to master 1.
               s1_pending_set = 1'b1;
            end
         end
         grant_m1:
         begin
            if (s1_arvalid)
               s1_pending_set = 1'b1;           // owner asks again, keep it.
            else if (s1_pending_q & ~last_done)
               grant_d = grant_m1;              // burst still running, path stays locked.
            else if (last_done)
               grant_d = grant_m0;              // round-robin after the last beat.
            else if (s0_arvalid)
            begin
               grant_d        = grant_m0;       // idle owner, hand over to master 0.
               s0_pending_set = 1'b1;
            end
         end
         default:
            grant_d = to_grant(init_owner);     // an illegal code falls back to the reset owner.
      endcase
   end

   //////////////////////////////
   // state registers
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         grant_q      <= to_grant(init_owner);  // start with the configured owner.
         s0_pending_q <= 1'b0;
         s1_pending_q <= 1'b0;
      end
      else
      begin
         grant_q <= grant_d;
         if (s0_pending_set | s0_pending_clr)
            s0_pending_q <= s0_pending_set;     // a new request wins over the clear.
         if (s1_pending_set | s1_pending_clr)
            s1_pending_q <= s1_pending_set;     // a new request wins over the clear.
      end
   end

   assign grant = grant_q;

endmodule

// File: src/axi4_r_demux.sv
//////////////////////////////
// R channel routing to two masters.
// The payload is broadcast and only rvalid is steered.
//////////////////////////////
`timescale 1ns/10ps

module axi4_r_demux
   import axi_pkg::*;
   import xbar_pkg::*;
(
   input  grant_t grant,                        // one-hot owner from the arbiter.
   // slave
   input  logic   m_rvalid,
   input  r_t     m_r,
   output logic   m_rready,
   // master 0
   output logic   s0_rvalid,
   output r_t     s0_r,
   input  logic   s0_rready,
   // master 1
   output logic   s1_rvalid,
   output r_t     s1_r,
   input  logic   s1_rready
);

   logic s0_sel;                                // master 0 owns the path.
   logic s1_sel;                                // master 1 owns the path.

   assign s0_sel = grant[0];
   assign s1_sel = grant[1];

   //////////////////////////////
   // toward the masters
   //////////////////////////////

   assign s0_rvalid = s0_sel & m_rvalid;        // a beat only shows up at the owner.
   assign s1_rvalid = s1_sel & m_rvalid;

   // both masters see the same payload. rvalid says whose it is.
   assign s0_r = m_r;
   assign s1_r = m_r;

   //////////////////////////////
   // back to the slave
   //////////////////////////////

   // the owner's rready alone paces the slave. The arbiter also uses it for rlast.
   assign m_rready = (s0_sel & s0_rready) | (s1_sel & s1_rready);

endmodule

// File: src/axi4_xbar_r.sv
//////////////////////////////
// Two master AXI4 read path to one slave.
// No write channels and no id remapping.
// One burst per master in flight, wait for rlast.
//////////////////////////////
`timescale 1ns/10ps

module axi4_xbar_r
   import axi_pkg::*;
   import xbar_pkg::*;
#(
   parameter mst_idx_t init_owner = 1'b0        // owner after reset.
)
(
   input  logic   clk,
   input  logic   rst_n,
   // master 0
   input  logic   s0_arvalid,
   input  ar_t    s0_ar,
   output logic   s0_arready,
   output logic   s0_rvalid,
   output r_t     s0_r,
   input  logic   s0_rready,
   // master 1
   input  logic   s1_arvalid,
   input  ar_t    s1_ar,
   output logic   s1_arready,
   output logic   s1_rvalid,
   output r_t     s1_r,
   input  logic   s1_rready,
   // slave
   output logic   m_arvalid,
   output ar_t    m_ar,
   input  logic   m_arready,
   input  logic   m_rvalid,
   input  r_t     m_r,
   output logic   m_rready,
   output grant_t m_rgrnt                       // current owner of the read path.
);

   grant_t grant;                               // shared steering for both channels.

   //////////////////////////////
   // owner
   //////////////////////////////

   axi4_arbiter_r #(
      .init_owner (init_owner)
   ) axi4_arbiter_r_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .s0_arvalid (s0_arvalid),
      .s1_arvalid (s1_arvalid),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),                   // already the owner's rready.
      .m_rlast    (m_r.rlast),
      .grant      (grant)
   );

   //////////////////////////////
   // channels
   //////////////////////////////

   axi4_ar_mux axi4_ar_mux_i (
      .grant      (grant),
      .s0_arvalid (s0_arvalid),
      .s0_ar      (s0_ar),
      .s0_arready (s0_arready),
      .s1_arvalid (s1_arvalid),
      .s1_ar      (s1_ar),
      .s1_arready (s1_arready),
      .m_arvalid  (m_arvalid),
      .m_ar       (m_ar),
      .m_arready  (m_arready)
   );

   axi4_r_demux axi4_r_demux_i (
      .grant      (grant),
      .m_rvalid   (m_rvalid),
      .m_r        (m_r),
      .m_rready   (m_rready),
      .s0_rvalid  (s0_rvalid),
      .s0_r       (s0_r),
      .s0_rready  (s0_rready),
      .s1_rvalid  (s1_rvalid),
      .s1_r       (s1_r),
      .s1_rready  (s1_rready)
   );

   assign m_rgrnt = grant;                      // grant is visible at the top.

endmodule

// File: src/axi_pkg.sv
//////////////////////////////
// AXI4 read channel payloads only. Widths are fixed here
// and are not module parameters.
//////////////////////////////

package axi_pkg;

   //////////////////////////////
   // channel widths
   //////////////////////////////

   localparam int addr_w  = 32;                 // byte address width.
   localparam int data_w  = 32;                 // read data width.
   localparam int id_w    = 4;                  // transaction id width.
   localparam int len_w   = 8;                  // arlen width, beats minus one.
   localparam int size_w  = 3;                  // arsize width.
   localparam int burst_w = 2;                  // arburst width.
   localparam int resp_w  = 2;                  // rresp width.

   localparam logic [resp_w-1:0] resp_okay = 2'b00; // normal access success.

   //////////////////////////////
   // payload structs
   //////////////////////////////

   // ar payload, 49 bits. araddr sits in the top bits.
   typedef struct packed
   {
      logic [addr_w-1:0]  araddr;               // start address of the burst.
      logic [id_w-1:0]    arid;                 // id returned on every r beat.
      logic [len_w-1:0]   arlen;                // number of beats minus one.
      logic [size_w-1:0]  arsize;               // bytes per beat as a power of two.
      logic [burst_w-1:0] arburst;              // burst type.
   } ar_t;

   // r payload, 39 bits.
   typedef struct packed
   {
      logic [data_w-1:0]  rdata;                // read data of this beat.
      logic [id_w-1:0]    rid;                  // id copied from the request.
      logic [resp_w-1:0]  rresp;                // response code of this beat.
      logic               rlast;                // high on the final beat only.
   } r_t;

endpackage

// File: src/xbar_pkg.sv
//////////////////////////////
// Grant encoding for a two master read path.
// Exactly one grant bit is set at all times.
//////////////////////////////

package xbar_pkg;

   typedef logic [1:0] grant_t;                 // one-hot owner, bit k is master k.
   typedef logic       mst_idx_t;               // master index, 0 or 1.

   localparam grant_t grant_m0 = 2'b01;         // master 0 owns the path.
   localparam grant_t grant_m1 = 2'b10;         // master 1 owns the path.

   // one-hot grant for a master index.
   function automatic grant_t to_grant(input mst_idx_t idx);
      grant_t g;
      g      = '0;                                // start with no owner.
      g[idx] = 1'b1;                              // set the owner bit.
      return g;
   endfunction

endpackage

// File: verification/axi4_xbar_r_tb.sv
//////////////////////////////
// Random read traffic from two masters into one slave.
// The run stops at the first mismatch.
//////////////////////////////
`timescale 1ns/10ps

module axi4_xbar_r_tb
   import axi_pkg::*;
   import xbar_pkg::*;
();

   localparam mst_idx_t init_owner        = 1'b0;
   localparam grant_t   init_grant        = grant_t'(1) << init_owner;
   localparam int       bursts_per_master = 40;
   localparam int       base_seed         = 32'h7eb1_d254;
   // all bursts times (8 beats plus 8 stall cycles) times 4 cycles of 100 ns.
   localparam int       watchdog_ns       = 2 * bursts_per_master * (8 + 8) * 4 * 100;

   logic       clk;
   logic       rst_n;
   logic [1:0] arvalid_v;                   // bit k is master k.
   ar_t        ar_m [2];
   logic [1:0] rready_v;
   logic [1:0] done_v;                      // master k issued all of its bursts.
   wire  [1:0] arready_v;
   wire  [1:0] rvalid_v;
   r_t         s0_r;
   r_t         s1_r;
   logic       m_arvalid;
   ar_t        m_ar;
   logic       m_arready;
   logic       m_rvalid;
   r_t         m_r;
   logic       m_rready;
   grant_t     m_rgrnt;

   r_t         exp_q0 [$];                  // beats still owed to master 0.
   r_t         exp_q1 [$];                  // beats still owed to master 1.
   int         bursts_tx [2];
   int         bursts_rx [2];
   logic       have_prev;                   // an AR has reached the slave before.
   logic       prev_src;
   logic       src;
   logic [1:0] ar_gap_seen;                 // master k dropped arvalid since the last AR.
   logic       burst_open;
   grant_t     burst_grant;

   tb_clock #(.period_ns (100), .reset_cycles (4)) tb_clock_i (.clk (clk), .rst_n (rst_n));

   axi4_xbar_r #(
      .init_owner (init_owner)
   ) axi4_xbar_r_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .s0_arvalid (arvalid_v[0]),
      .s0_ar      (ar_m[0]),
      .s0_arready (arready_v[0]),
      .s0_rvalid  (rvalid_v[0]),
      .s0_r       (s0_r),
      .s0_rready  (rready_v[0]),
      .s1_arvalid (arvalid_v[1]),
      .s1_ar      (ar_m[1]),
      .s1_arready (arready_v[1]),
      .s1_rvalid  (rvalid_v[1]),
      .s1_r       (s1_r),
      .s1_rready  (rready_v[1]),
      .m_arvalid  (m_arvalid),
      .m_ar       (m_ar),
      .m_arready  (m_arready),
      .m_rvalid   (m_rvalid),
      .m_r        (m_r),
      .m_rready   (m_rready),
      .m_rgrnt    (m_rgrnt)
   );

   tb_axi_slave #(
      .seed_init (base_seed + 2)
   ) tb_axi_slave_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .arvalid (m_arvalid),
      .ar      (m_ar),
      .arready (m_arready),
      .rvalid  (m_rvalid),
      .r       (m_r),
      .rready  (m_rready)
   );

   //////////////////////////////
   // checks and the model
   //////////////////////////////

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_r(input string name, input r_t got, input r_t exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_grant(input string name, input grant_t got, input grant_t exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   // every beat of a burst is known as soon as its AR is accepted.
   task automatic push_expected(input mst_idx_t k, input ar_t a);
      r_t e;
      for (int b = 0; b <= a.arlen; b++)
      begin
         e.rdata = a.araddr + 4 * b;
         e.rid   = a.arid;
         e.rresp = 2'b00;                   // okay.
         e.rlast = (b == a.arlen);
         if (k)
            exp_q1.push_back(e);
         else
            exp_q0.push_back(e);
      end
   endtask

   task automatic take_beat(input mst_idx_t k, input r_t got);
      r_t e;
      if ((k ? exp_q1.size() : exp_q0.size()) == 0)
         abort_run($sformatf("master %0d received a beat it never asked for", k));
      if (k)
         e = exp_q1.pop_front();
      else
         e = exp_q0.pop_front();
      check_r(k ? "s1_r" : "s0_r", got, e);
      if (got.rlast)
         bursts_rx[k]++;
   endtask

   //////////////////////////////
   // masters
   //////////////////////////////

   task automatic issue_bursts(input mst_idx_t k);
      integer seed;
      int     gap;
      ar_t    req;
      logic   hs;
      seed = base_seed + k;                 // each master has its own stream.
      wait (rst_n === 1'b1);
      @(posedge clk);
      for (int n = 0; n < bursts_per_master; n++)
      begin
         gap = $random(seed) & 7;
         if (gap > 2)
            gap = 0;                        // mostly back to back so both keep asking.
         repeat (gap) @(posedge clk);
         req.araddr      = $random(seed);
         req.araddr[31]  = k;               // bit 31 tells the masters apart.
         req.araddr[1:0] = 2'b00;
         req.arid        = k;
         req.arlen       = $random(seed) & 7;
         req.arsize      = 3'd2;
         req.arburst     = 2'b01;           // incr.
         arvalid_v[k] <= 1'b1;
         ar_m[k]      <= req;
         hs = 1'b0;
         while (!hs)
         begin
            @(posedge clk);
            hs = arready_v[k];
         end
         arvalid_v[k] <= 1'b0;
         hs = 1'b0;
         while (!hs)                        // only one burst may be in flight until rlast.
         begin
            rready_v[k] <= ($random(seed) & 3) != 0;
            @(posedge clk);
            hs = rvalid_v[k] && rready_v[k] && (k ? s1_r.rlast : s0_r.rlast);
         end
      end
      rready_v[k] <= 1'b0;
      done_v[k] = 1'b1;
   endtask

   initial
   begin
      arvalid_v    = '0;
      rready_v     = '0;
      done_v       = '0;
      ar_m[0]      = '0;
      ar_m[1]      = '0;
      bursts_tx    = '{0, 0};
      bursts_rx    = '{0, 0};
      have_prev    = 1'b0;
      prev_src     = 1'b0;
      ar_gap_seen  = '0;
      burst_open   = 1'b0;
      burst_grant  = '0;
   end

   initial
      issue_bursts(1'b0);

   initial
      issue_bursts(1'b1);

   //////////////////////////////
   // monitor at the falling edge
   //////////////////////////////

   always @(negedge clk)
   begin
      if (rst_n === 1'b1)
      begin
         if (m_rgrnt !== 2'b01 && m_rgrnt !== 2'b10)
            abort_run($sformatf("m_rgrnt is not one-hot, it reads %h", m_rgrnt));
         if (rvalid_v[0] && !m_rgrnt[0])
            abort_run("rvalid went to master 0 while master 1 held the grant");
         if (rvalid_v[1] && !m_rgrnt[1])
            abort_run("rvalid went to master 1 while master 0 held the grant");
         for (int k = 0; k < 2; k++)
         begin
            if (arvalid_v[k] && arready_v[k])
            begin
               push_expected(k[0], ar_m[k]);
               bursts_tx[k]++;
            end
            if (rvalid_v[k] && rready_v[k])
               take_beat(k[0], k ? s1_r : s0_r);
         end
         if (burst_open)                    // the owner is locked until rlast.
         begin
            check_grant("m_rgrnt", m_rgrnt, burst_grant);
            if (m_rvalid && m_rready && m_r.rlast)
               burst_open = 1'b0;
         end
         if (m_arvalid && m_arready)
         begin
            src = m_ar.araddr[31];
            check_grant("m_rgrnt", m_rgrnt, src ? 2'b10 : 2'b01);
            // a repeat is only legal if the other master let go of arvalid.
            if (have_prev && src == prev_src && !ar_gap_seen[~src])
               abort_run($sformatf("master %0d got two bursts in a row while the other waited",
                                   src));
            have_prev   = 1'b1;
            prev_src    = src;
            ar_gap_seen = '0;
            burst_open  = 1'b1;
            burst_grant = src ? 2'b10 : 2'b01;
         end
         else
            ar_gap_seen = ar_gap_seen | ~arvalid_v;
      end
   end

   //////////////////////////////
   // run control
   //////////////////////////////

   initial
   begin
      #(watchdog_ns);
      abort_run("the run hung, the watchdog expired before all bursts completed");
   end

   initial
   begin
      wait (rst_n === 1'b1);
      @(negedge clk);
      check_grant("m_rgrnt", m_rgrnt, init_grant); // no request has been made yet.
      wait (done_v == 2'b11);
      @(negedge clk);
      check_count("bursts_tx[0]", bursts_tx[0], bursts_per_master);
      check_count("bursts_tx[1]", bursts_tx[1], bursts_per_master);
      check_count("bursts_rx[0]", bursts_rx[0], bursts_per_master);
      check_count("bursts_rx[1]", bursts_rx[1], bursts_per_master);
      check_count("exp_q0.size", exp_q0.size(), 0);
      check_count("exp_q1.size", exp_q1.size(), 0);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: verification/tb_axi_slave.sv
//////////////////////////////
// Behavioral read slave, one burst at a time.
// Beat b returns araddr plus 4*b with the request's id.
//////////////////////////////
`timescale 1ns/10ps

module tb_axi_slave
   import axi_pkg::*;
#(
   parameter int seed_init = 0              // private seed for the stall pattern.
)
(
   input  logic clk,
   input  logic rst_n,
   input  logic arvalid,
   input  ar_t  ar,
   output logic arready,
   output logic rvalid,
   output r_t   r,
   input  logic rready
);

   integer           seed;                  // $random state.
   logic             busy;                  // a burst is being returned.
   ar_t              req;                   // the accepted request.
   logic [len_w-1:0] beat;                  // index of the current beat.

   initial
   begin
      seed    = seed_init;
      arready = 1'b0;
      rvalid  = 1'b0;
      busy    = 1'b0;
      req     = '0;
      beat    = '0;
   end

   // the payload follows the beat index and rvalid alone says when it counts.
   always_comb
   begin
      r.rdata = req.araddr + (data_w'(beat) << 2); // four bytes per beat.
      r.rid   = req.arid;
      r.rresp = resp_okay;                   // always okay.
      r.rlast = (beat == req.arlen);
   end

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         busy    <= 1'b0;
         beat    <= '0;
      end
      else if (!busy)
      begin
         if (arvalid && arready)
         begin
            req     <= ar;                   // take the request.
            beat    <= '0;
            busy    <= 1'b1;
            arready <= 1'b0;                 // no new request until rlast.
            rvalid  <= ($random(seed) & 3) != 0;
         end
         else
            arready <= ($random(seed) & 3) != 0; // ready three cycles in four.
      end
      else if (rvalid && rready)
      begin
         if (r.rlast)
         begin
            busy   <= 1'b0;                  // burst done, back to idle.
            rvalid <= 1'b0;
         end
         else
         begin
            beat   <= beat + 1'b1;
            rvalid <= ($random(seed) & 3) != 0; // may stall before the next beat.
         end
      end
      else if (!rvalid)
         rvalid <= ($random(seed) & 3) != 0; // once raised, rvalid holds until taken.
   end

endmodule

// File: verification/tb_clock.sv
//////////////////////////////
// Free running clock and a synchronous, active low reset.
//////////////////////////////
`timescale 1ns/10ps

module tb_clock
#(
   parameter int period_ns    = 100,        // clock period in ns.
   parameter int reset_cycles = 4           // rising edges with rst_n low.
)
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever
         #(period_ns / 2) clk = ~clk;        // half period high, half low.
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;                         // released on an edge like any other input.
   end

endmodule
